// File: cam_filter.f
+incdir+rtl
rtl/cam_filter_pkg.sv
rtl/cam_input_sync.sv
rtl/cam_byte_decoder.sv
rtl/pixel_filter.sv
rtl/frame_writer.sv
rtl/filter_apb_regs.sv
rtl/cam_filter_top.sv
dv/tb_cam_filter.sv

// File: dv/tb_cam_filter.sv
`timescale 1ns/1ns
`include "cam_filter_settings.svh"

module tb_cam_filter;
   import cam_filter_pkg::*;

   localparam int clk_half   = 5;         // 10 ns period
   localparam int wait_limit = 4000;      // cycles, any single wait
   localparam int run_limit  = 2000000;   // ns, whole run

   logic      clk_65mhz;
   logic      reset_in;
   cam_bus_t  cam_pins;
   logic      xclk;
   apb_req_t  apb_req;
   apb_rsp_t  apb_rsp;
   fb_write_t fb_wr;

   logic [31:0] lfsr;
   rgb565_t     model_prev;       // last pixel sent, any mode
   fb_addr_t    model_addr;
   int          model_frames;     // vsync pulses driven
   logic [2:0]  model_mode;
   fb_addr_t    exp_addr_q [$];
   rgb444_t     exp_data_q [$];
   int          checks;
   int          errors;
   int          test_base;

   cam_filter_top i_dut (
      .clk_65mhz (clk_65mhz),
      .reset_in  (reset_in),
      .cam_pins  (cam_pins),
      .xclk      (xclk),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .fb_wr     (fb_wr)
   );

   initial begin
      clk_65mhz = 1'b0;
      forever #clk_half clk_65mhz = ~clk_65mhz;
   end

   //////////////////////
   // helpers
   //////////////////////
   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic tick(input int n);
      repeat (n) @(posedge clk_65mhz);
      #1;                                  // drive just after the edge
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act) else begin
         errors++;
         $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic report_test(input string name);
      $display("%s: %0s, %0d errors", name, (errors == test_base) ? "ok" : "bad",
               errors - test_base);
      test_base = errors;
   endtask

   //////////////////////
   // reference model
   //////////////////////
   function automatic chan_t chan_dist(input chan_t a, input chan_t b);
      int d;
      d = int'(a) - int'(b);
      if (d < 0) d = -d;
      return chan_t'(d);
   endfunction

   // top 4 bits of each 565 field
   function automatic rgb444_t model_filter(input logic [2:0] m, input rgb565_t p,
                                            input rgb565_t q);
      chan_t r, g, b;
      r = p[15:12];
      g = p[10:7];
      b = p[4:1];
      case (m)
         3'd1: return {chan_dist(r, q[15:12]), chan_dist(g, q[10:7]), chan_dist(b, q[4:1])};
         3'd2: return (r > `CHAN_MID && g < `CHAN_MID && b < `CHAN_MID) ? 12'hf00 : 12'h000;
         3'd3: return (g > `CHAN_MID && r < `CHAN_MID && b < `CHAN_MID) ? 12'h0f0 : 12'h000;
         3'd4: return (b > `CHAN_MID && r < `CHAN_MID && g < `CHAN_MID) ? 12'h00f : 12'h000;
         default: return {r, g, b};        // pass and the unused codes
      endcase
   endfunction

   function automatic rgb565_t pack_chans(input chan_t r, input chan_t g, input chan_t b,
                                          input logic [3:0] low);
      return {r, low[3], g, low[2:1], b, low[0]};
   endfunction

   // hot = 1 red, 2 green, 3 blue, 0 plain random
   function automatic rgb565_t pick_pixel(input int hot);
      chan_t       c [3];
      logic [1:0]  sel;
      logic [31:0] r;
      r   = rand_bits(2);
      sel = r[1:0];
      if (hot == 0 || sel[1]) begin
         r = rand_bits(16);
         return r[15:0];
      end
      for (int i = 0; i < 3; i++) begin
         r    = rand_bits(3);
         c[i] = {1'b0, r[2:0]};              // cold, under threshold
      end
      r = rand_bits(3);
      c[hot-1] = sel[0] ? chan_t'(`CHAN_MID) : {1'b1, r[2:0]};  // exactly at mid or above
      r = rand_bits(4);
      return pack_chans(c[0], c[1], c[2], r[3:0]);
   endfunction

   //////////////////////
   // camera driver
   //////////////////////
   task automatic send_byte(input cam_byte_t b);
      cam_pins.pclk = 1'b0;
      cam_pins.data = b;
      tick(4);
      cam_pins.pclk = 1'b1;
      tick(4);
   endtask

   task automatic send_pixel(input rgb565_t p);
      exp_addr_q.push_back(model_addr);
      exp_data_q.push_back(model_filter(model_mode, p, model_prev));
      model_prev = p;
      model_addr++;
      send_byte(p[15:8]);                  // high byte first
      send_byte(p[7:0]);
   endtask

   task automatic send_line(input int n, input int hot);
      cam_pins.href = 1'b1;
      for (int i = 0; i < n; i++) begin
         send_pixel(pick_pixel(hot));
      end
      cam_pins.pclk = 1'b0;
      cam_pins.href = 1'b0;                // blanking between lines
      tick(6);
   endtask

   task automatic send_frame(input int lines, input int hot);
      cam_pins.vsync = 1'b1;
      tick(4);
      cam_pins.vsync = 1'b0;
      model_addr = '0;                     // writer restarts each frame
      model_frames++;
      tick(6);
      for (int i = 0; i < lines; i++) begin
         send_line(1 + rand_bits(3), hot);   // 1 to 8 pixels
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_addr_q.size() != 0 && n < wait_limit) begin
         tick(1);
         n++;
      end
      checks++;
      assert (exp_addr_q.size() == 0) else begin
         errors++;
         $display("timeout at %0t: %0d frame buffer writes never arrived", $time,
                  exp_addr_q.size());
      end
      tick(4);                             // a late extra write still gets seen
   endtask

   //////////////////////
   // apb driver
   //////////////////////
   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                           output apb_data_t rdata, output logic err);
      int n;
      apb_req.psel    = 1'b1;              // setup phase
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      tick(1);
      apb_req.penable = 1'b1;              // access phase
      #2;
      n = 0;
      while (!apb_rsp.pready && n < wait_limit) begin
         tick(1);
         #2;
         n++;
      end
      checks++;
      assert (apb_rsp.pready) else begin
         errors++;
         $display("timeout at %0t: apb slave never raised pready", $time);
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      tick(1);                             // transfer ends on this edge
      apb_req = '0;
   endtask

   task automatic set_mode(input logic [2:0] m);
      apb_data_t rd;
      logic      err;
      apb_xfer(1'b1, apb_addr_t'(`REG_MODE_OFS), apb_data_t'(m), rd, err);
      check_val("pslverr", 32'd0, 32'(err));
      model_mode = m;
   endtask

   //////////////////////
   // write monitor
   //////////////////////
   always @(negedge clk_65mhz) begin
      if (!reset_in && fb_wr.we) begin
         checks++;
         assert (exp_addr_q.size() != 0) else begin
            errors++;
            $display("error at %0t: frame buffer write with none expected", $time);
         end
         if (exp_addr_q.size() != 0) begin
            check_val("fb_wr.addr", 32'(exp_addr_q.pop_front()), 32'(fb_wr.addr));
            check_val("fb_wr.data", 32'(exp_data_q.pop_front()), 32'(fb_wr.data));
         end
      end
   end

   // hard stop if something hangs
   initial begin
      #run_limit;
      $display("error: simulation ran past its time limit");
      $display("test failed");
      $finish;
   end

   initial begin
      apb_data_t rd;
      logic      err;
      logic      xs [40];
      lfsr         = 32'h680d;
      checks       = 0;
      errors       = 0;
      test_base    = 0;
      model_prev   = '0;
      model_addr   = '0;
      model_frames = 0;
      model_mode   = 3'd0;
      cam_pins     = '0;
      apb_req      = '0;
      reset_in     = 1'b1;
      tick(2);
      reset_in = 1'b0;
      tick(2);

      // register access and error responses
      apb_xfer(1'b1, apb_addr_t'(`REG_MODE_OFS), 32'd3, rd, err);
      check_val("pslverr", 32'd0, 32'(err));
      apb_xfer(1'b0, apb_addr_t'(`REG_MODE_OFS), 32'd0, rd, err);
      check_val("prdata", 32'd3, rd);
      apb_xfer(1'b0, 8'h08, 32'd0, rd, err);                   // unmapped
      check_val("pslverr", 32'd1, 32'(err));
      check_val("prdata", 32'd0, rd);
      apb_xfer(1'b1, apb_addr_t'(`REG_FRAME_OFS), 32'h55, rd, err);  // read only
      check_val("pslverr", 32'd1, 32'(err));
      apb_xfer(1'b0, apb_addr_t'(`REG_FRAME_OFS), 32'd0, rd, err);
      check_val("prdata", 32'd0, rd);
      report_test("apb access");

      set_mode(3'd0);
      for (int f = 0; f < 2; f++) begin
         send_frame(2 + rand_bits(2), 0);
      end
      wait_drain();
      report_test("pass mode");

      set_mode(3'd1);
      send_frame(3, 0);
      wait_drain();
      report_test("motion mode");

      for (int m = 2; m <= 4; m++) begin
         set_mode(m[2:0]);
         send_frame(3, m - 1);              // hot channel follows the mode
      end
      wait_drain();
      report_test("colour detect");

      set_mode(3'd6);                       // unused code filters as pass
      send_frame(2, 0);
      wait_drain();
      apb_xfer(1'b0, apb_addr_t'(`REG_MODE_OFS), 32'd0, rd, err);
      check_val("prdata", 32'd6, rd);
      apb_xfer(1'b0, apb_addr_t'(`REG_FRAME_OFS), 32'd0, rd, err);
      check_val("frame_count", 32'(model_frames), rd);
      check_val("pslverr", 32'd0, 32'(err));
      report_test("frame restart");

      for (int i = 0; i < 40; i++) begin
         tick(1);
         xs[i] = xclk;
      end
      for (int i = 2; i < 40; i++) begin
         if (i >= 4) check_val("xclk", 32'(xs[i-4]), 32'(xs[i]));   // period 4
         checks++;
         assert (xs[i] !== xs[i-2]) else begin                      // 2 high, 2 low
            errors++;
            $display("error at %0t: xclk is not high for exactly 2 of 4 cycles", $time);
         end
      end
      report_test("xclk");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: rtl/cam_byte_decoder.sv
`timescale 1ns/1ns

module cam_byte_decoder (
   input  logic                       clk_65mhz,
   input  logic                       reset_in,
   input  cam_filter_pkg::cam_bus_t    cam_synced,
   input  logic                       pclk_rise,
   output cam_filter_pkg::pixel_beat_t pixel_beat,
   output logic                       frame_start
);
   import cam_filter_pkg::*;

   byte_phase_t phase;
   cam_byte_t   high_byte;       // first byte of the pair
   logic        vsync_prev;
   logic        beat_valid;
   rgb565_t     beat_pixel;
   logic        take_byte;

   // a byte is only real while href is up
   assign take_byte = pclk_rise & cam_synced.href;

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         phase       <= first_byte;
         beat_valid  <= 1'b0;
         vsync_prev  <= 1'b0;
         frame_start <= 1'b0;
      end else begin
         beat_valid  <= 1'b0;                                // one cycle pulse
         vsync_prev  <= cam_synced.vsync;
         frame_start <= cam_synced.vsync & ~vsync_prev;      // vsync rising
         if (!cam_synced.href) begin
            phase <= first_byte;                             // realign every line
         end else if (take_byte) begin
            case (phase)
               first_byte:  phase <= second_byte;
               second_byte: begin
                  phase      <= first_byte;
                  beat_valid <= 1'b1;
               end
               default:     phase <= first_byte;
            endcase
         end
      end
   end

   // byte capture and pixel assembly
   always_ff @(posedge clk_65mhz) begin
      if (take_byte && phase == first_byte) begin
         high_byte <= cam_synced.data;
      end
      if (take_byte && phase == second_byte) begin
         beat_pixel <= {high_byte, cam_synced.data};  // high byte first
      end
   end

   assign pixel_beat = '{valid: beat_valid, pixel: beat_pixel};

endmodule

// File: rtl/cam_filter_pkg.sv
`include "cam_filter_settings.svh"

package cam_filter_pkg;

   ////////////////////
   // vector types
   ////////////////////
   typedef logic [`CAM_BYTE_W-1:0]  cam_byte_t;
   typedef logic [`RGB565_W-1:0]    rgb565_t;    // r 15:11, g 10:5, b 4:0
   typedef logic [`RGB444_W-1:0]    rgb444_t;    // r 11:8, g 7:4, b 3:0
   typedef logic [`CHAN_W-1:0]      chan_t;
   typedef logic [`FB_ADDR_W-1:0]   fb_addr_t;
   typedef logic [`FRAME_CNT_W-1:0] frame_cnt_t;
   typedef logic [`APB_ADDR_W-1:0]  apb_addr_t;
   typedef logic [`APB_DATA_W-1:0]  apb_data_t;

   // 5..7 are stored by the regs but filter as pass
   typedef enum logic [2:0] {
      mode_pass   = 3'd0,
      mode_motion = 3'd1,
      mode_red    = 3'd2,
      mode_green  = 3'd3,
      mode_blue   = 3'd4
   } filter_mode_t;

   typedef enum logic {
      first_byte,    // waiting for high byte
      second_byte    // high byte held, low byte next
   } byte_phase_t;

   ////////////////////
   // bundles
   ////////////////////
   typedef struct packed {
      logic      pclk;
      logic      vsync;
      logic      href;
      cam_byte_t data;
   } cam_bus_t;

   typedef struct packed {
      logic    valid;
      rgb565_t pixel;
   } pixel_beat_t;

   typedef struct packed {
      logic    valid;
      rgb444_t pixel;
   } filt_beat_t;

   typedef struct packed {
      logic     we;
      fb_addr_t addr;
      rgb444_t  data;
   } fb_write_t;

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      logic      pready;
      logic      pslverr;
      apb_data_t prdata;
   } apb_rsp_t;

endpackage

// File: rtl/cam_filter_settings.svh
`ifndef CAM_FILTER_SETTINGS_SVH
`define CAM_FILTER_SETTINGS_SVH

// camera side
`define CAM_BYTE_W    8      // camera data pins
`define RGB565_W      16     // two bytes per pixel
`define RGB444_W      12     // filtered pixel
`define CHAN_W        4      // one filtered channel
`define CHAN_MID      8      // colour detect threshold

// frame buffer, 320 x 240
`define FB_ADDR_W     17
`define FRAME_PIXELS  76800
`define FRAME_CNT_W   16

// register bus
`define APB_ADDR_W    8
`define APB_DATA_W    32
`define REG_MODE_OFS  'h0    // filter mode, rw
`define REG_FRAME_OFS 'h4    // frames seen, ro

`define XCLK_DIV_W    2      // xclk = clk_65mhz / 4

`endif

// File: rtl/cam_filter_top.sv
`timescale 1ns/1ns

module cam_filter_top (
   input  logic                     clk_65mhz,
   input  logic                     reset_in,
   input  cam_filter_pkg::cam_bus_t  cam_pins,
   output logic                     xclk,
   input  cam_filter_pkg::apb_req_t  apb_req,
   output cam_filter_pkg::apb_rsp_t  apb_rsp,
   output cam_filter_pkg::fb_write_t fb_wr      // to the frame buffer ram
);
   import cam_filter_pkg::*;

   cam_bus_t     cam_synced;
   logic         pclk_rise;
   pixel_beat_t  pixel_beat;      // decode -> execute
   logic         frame_start;
   filt_beat_t   filt_beat;       // execute -> result
   frame_cnt_t   frame_count;
   filter_mode_t mode;

   cam_input_sync i_sync (
      .clk_65mhz  (clk_65mhz),
      .reset_in   (reset_in),
      .cam_pins   (cam_pins),
      .cam_synced (cam_synced),
      .pclk_rise  (pclk_rise),
      .xclk       (xclk)
   );

   cam_byte_decoder i_decode (
      .clk_65mhz   (clk_65mhz),
      .reset_in    (reset_in),
      .cam_synced  (cam_synced),
      .pclk_rise   (pclk_rise),
      .pixel_beat  (pixel_beat),
      .frame_start (frame_start)
   );

   pixel_filter i_filter (
      .clk_65mhz  (clk_65mhz),
      .reset_in   (reset_in),
      .pixel_beat (pixel_beat),
      .mode       (mode),
      .filt_beat  (filt_beat)
   );

   frame_writer i_writer (
      .clk_65mhz   (clk_65mhz),
      .reset_in    (reset_in),
      .filt_beat   (filt_beat),
      .frame_start (frame_start),
      .fb_wr       (fb_wr),
      .frame_count (frame_count)
   );

   filter_apb_regs i_regs (
      .clk_65mhz   (clk_65mhz),
      .reset_in    (reset_in),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .frame_count (frame_count),
      .mode        (mode)
   );

endmodule

// File: rtl/cam_input_sync.sv
`timescale 1ns/1ns
`include "cam_filter_settings.svh"

module cam_input_sync (
   input  logic                    clk_65mhz,
   input  logic                    reset_in,
   input  cam_filter_pkg::cam_bus_t cam_pins,    // straight from the pmod pins
   output cam_filter_pkg::cam_bus_t cam_synced,
   output logic                    pclk_rise,
   output logic                    xclk         // drive clock to the camera
);
   import cam_filter_pkg::*;

   cam_bus_t                cam_meta;    // first flop, may go metastable
   logic                    pclk_prev;
   logic [`XCLK_DIV_W-1:0]  xclk_div;

   ////////////////////
   // pin sync
   ////////////////////
   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         cam_meta   <= '0;
         cam_synced <= '0;
         pclk_prev  <= 1'b0;
         pclk_rise  <= 1'b0;
      end else begin
         cam_meta   <= cam_pins;
         cam_synced <= cam_meta;              // two flops on every pin
         pclk_prev  <= cam_synced.pclk;
         // pulse the cycle after synced pclk goes high
         pclk_rise  <= cam_synced.pclk & ~pclk_prev;
      end
   end

   ////////////////////
   // xclk divider
   ////////////////////
   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         xclk_div <= '0;
      end else begin
         xclk_div <= xclk_div + 1'b1;        // free running
      end
   end

   // upper half of the count, high on counts 2 and 3
   assign xclk = xclk_div[`XCLK_DIV_W-1];

endmodule

// File: rtl/filter_apb_regs.sv
`timescale 1ns/1ns
`include "cam_filter_settings.svh"

module filter_apb_regs (
   input  logic                        clk_65mhz,
   input  logic                        reset_in,
   input  cam_filter_pkg::apb_req_t     apb_req,
   output cam_filter_pkg::apb_rsp_t     apb_rsp,
   input  cam_filter_pkg::frame_cnt_t   frame_count,
   output cam_filter_pkg::filter_mode_t mode
);
   import cam_filter_pkg::*;

   logic access;         // second phase of a transfer
   logic hit_mode;
   logic hit_frame;

   assign access    = apb_req.psel & apb_req.penable;
   assign hit_mode  = apb_req.paddr == apb_addr_t'(`REG_MODE_OFS);
   assign hit_frame = apb_req.paddr == apb_addr_t'(`REG_FRAME_OFS);

   ////////////////////
   // mode register
   ////////////////////
   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         mode <= mode_pass;
      end else if (access && apb_req.pwrite && hit_mode) begin
         mode <= filter_mode_t'(apb_req.pwdata[2:0]);   // any 3 bit value kept
      end
   end

   ////////////////////
   // response
   ////////////////////
   always_comb begin
      apb_rsp.pready  = access;                         // never waits
      apb_rsp.pslverr = access & ((~hit_mode & ~hit_frame) |
                                  (apb_req.pwrite & hit_frame)); // frame count is ro
      if (hit_mode) begin
         apb_rsp.prdata = apb_data_t'(mode);
      end else if (hit_frame) begin
         apb_rsp.prdata = apb_data_t'(frame_count);
      end else begin
         apb_rsp.prdata = '0;                           // unmapped reads zero
      end
   end

endmodule

// File: rtl/frame_writer.sv
`timescale 1ns/1ns
`include "cam_filter_settings.svh"

module frame_writer (
   input  logic                      clk_65mhz,
   input  logic                      reset_in,
   input  cam_filter_pkg::filt_beat_t filt_beat,
   input  logic                      frame_start,
   output cam_filter_pkg::fb_write_t  fb_wr,
   output cam_filter_pkg::frame_cnt_t frame_count
);
   import cam_filter_pkg::*;

   localparam fb_addr_t frame_end = fb_addr_t'(`FRAME_PIXELS);

   fb_addr_t wr_addr;       // next address to write
   logic     accept;
   logic     we_q;
   fb_addr_t addr_q;
   rgb444_t  data_q;

   // drop beats once the frame is full
   assign accept = filt_beat.valid & ~frame_start & (wr_addr < frame_end);

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         wr_addr     <= '0;
         we_q        <= 1'b0;
         frame_count <= '0;
      end else begin
         we_q <= accept;
         if (frame_start) begin
            wr_addr     <= '0;                    // new frame, back to the top
            frame_count <= frame_count + 1'b1;    // wraps
         end else if (accept) begin
            wr_addr <= wr_addr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_65mhz) begin
      if (accept) begin
         addr_q <= wr_addr;
         data_q <= filt_beat.pixel;
      end
   end

   assign fb_wr = '{we: we_q, addr: addr_q, data: data_q};

endmodule

// File: rtl/pixel_filter.sv
`timescale 1ns/1ns
`include "cam_filter_settings.svh"

module pixel_filter (
   input  logic                        clk_65mhz,
   input  logic                        reset_in,
   input  cam_filter_pkg::pixel_beat_t  pixel_beat,
   input  cam_filter_pkg::filter_mode_t mode,
   output cam_filter_pkg::filt_beat_t   filt_beat
);
   import cam_filter_pkg::*;

   localparam chan_t chan_mid  = chan_t'(`CHAN_MID);
   localparam chan_t chan_full = '1;
   localparam chan_t chan_zero = '0;

   chan_t   red, green, blue;                   // top 4 bits of each 565 field
   chan_t   prev_red, prev_green, prev_blue;
   rgb565_t prev_pixel;                         // last valid pixel, any mode
   rgb444_t filt_next;
   logic    filt_valid;
   rgb444_t filt_pixel;

   function automatic chan_t abs_diff(input chan_t a, input chan_t b);
      abs_diff = (a > b) ? a - b : b - a;
   endfunction

   // hot channel over threshold, both others under it
   function automatic logic only_hot(input chan_t hot, input chan_t c1, input chan_t c2);
      only_hot = (hot > chan_mid) && (c1 < chan_mid) && (c2 < chan_mid);
   endfunction

   assign red        = pixel_beat.pixel[15:12];
   assign green      = pixel_beat.pixel[10:7];
   assign blue       = pixel_beat.pixel[4:1];
   assign prev_red   = prev_pixel[15:12];
   assign prev_green = prev_pixel[10:7];
   assign prev_blue  = prev_pixel[4:1];

   ////////////////////
   // mode select
   ////////////////////
   always_comb begin
      case (mode)
         mode_motion: filt_next = {abs_diff(red, prev_red),
                                   abs_diff(green, prev_green),
                                   abs_diff(blue, prev_blue)};
         mode_red:    filt_next = only_hot(red, green, blue) ?
                                  {chan_full, chan_zero, chan_zero} : '0;
         mode_green:  filt_next = only_hot(green, red, blue) ?
                                  {chan_zero, chan_full, chan_zero} : '0;
         mode_blue:   filt_next = only_hot(blue, red, green) ?
                                  {chan_zero, chan_zero, chan_full} : '0;
         default:     filt_next = {red, green, blue};   // pass, also 5..7
      endcase
   end

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         filt_valid <= 1'b0;
         prev_pixel <= '0;                      // motion starts against black
      end else begin
         filt_valid <= pixel_beat.valid;
         if (pixel_beat.valid) begin
            prev_pixel <= pixel_beat.pixel;     // held across lines and frames
         end
      end
   end

   always_ff @(posedge clk_65mhz) begin
      if (pixel_beat.valid) begin
         filt_pixel <= filt_next;
      end
   end

   assign filt_beat = '{valid: filt_valid, pixel: filt_pixel};

endmodule
